//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_arkanoid_controls
FILELIST  = arkanoid_controls.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- arkanoid_controls.f
+incdir+.
arkanoid_controls_pkg.sv
player_buttons.sv
emulated_spinner.sv
encoder_input.sv
dip_switch_bank.sv
arkanoid_controls.sv
tb_arkanoid_controls.sv

//--- arkanoid_controls.sv
// Player input front end of the paddle machine
// Buttons, emulated spinner, real encoder select, DIP bank
// user_in: [0] encoder A, [1] encoder B, [3] fire pin

`timescale 1ns/1ns

module arkanoid_controls #(
	parameter int step_div   = 1500,  // About 4 kHz step rate at 6 MHz enable
	parameter int poll_ticks = 48000  // About 8 ms, mouse poll rate
) (
	input  logic        CLK_12M,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	input  logic [24:0] ps2_mouse,
	input  logic [8:0]  joy,
	input  logic [3:0]  user_in,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [1:0]  spinner,
	output logic        btn_shot,
	output logic        btn_service,
	output logic        btn_1p_start,
	output logic        btn_2p_start,
	output logic        coin1,
	output logic        coin2,
	output logic [7:0]  dip_sw
);

	logic       left;
	logic       right;
	logic       fast;
	logic [1:0] emu_spinner;
	logic       emu_active;

	////////////////////////////////////////////////////////////
	// Buttons
	////////////////////////////////////////////////////////////
	player_buttons u_buttons (
		.CLK_12M       (CLK_12M),
		.rst_n         (rst_n),
		.ps2_key       (ps2_key),
		.ps2_mouse_btn (ps2_mouse[1:0]),
		.joy           (joy),
		.fire_n        (user_in[3]),
		.left          (left),
		.right         (right),
		.fast          (fast),
		.btn_shot      (btn_shot),
		.btn_service   (btn_service),
		.btn_1p_start  (btn_1p_start),
		.btn_2p_start  (btn_2p_start),
		.coin1         (coin1),
		.coin2         (coin2)
	);

	////////////////////////////////////////////////////////////
	// Spinner sources
	////////////////////////////////////////////////////////////
	emulated_spinner #(
		.step_div   (step_div),
		.poll_ticks (poll_ticks)
	) u_emu (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.ps2_mouse   (ps2_mouse),
		.left        (left),
		.right       (right),
		.fast        (fast),
		.emu_spinner (emu_spinner),
		.emu_active  (emu_active)
	);

	encoder_input u_enc (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.enc_a       (user_in[0]),
		.enc_b       (user_in[1]),
		.emu_spinner (emu_spinner),
		.emu_active  (emu_active),
		.spinner     (spinner)
	);

	// DIP bytes from the loader
	dip_switch_bank u_dip (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_sw      (dip_sw)
	);

endmodule

//--- arkanoid_controls_pkg.sv
// Shared constants for the paddle input front end
// PS/2 scan codes, loader DIP index, spinner widths
// Quadrature step function for real and emulated spinner

package arkanoid_controls_pkg;

	////////////////////////////////////////////////////////////
	// PS/2 set 2 scan codes
	////////////////////////////////////////////////////////////
	localparam logic [7:0] key_start1  = 8'h16; // 1
	localparam logic [7:0] key_start2  = 8'h1E; // 2
	localparam logic [7:0] key_coin1   = 8'h2E; // 5
	localparam logic [7:0] key_coin2   = 8'h36; // 6
	localparam logic [7:0] key_service = 8'h46; // 9
	localparam logic [7:0] key_fast    = 8'h11; // Alt
	localparam logic [7:0] key_left    = 8'h6B; // Cursor left
	localparam logic [7:0] key_right   = 8'h74; // Cursor right
	localparam logic [7:0] key_fire    = 8'h29; // Space

	////////////////////////////////////////////////////////////
	// Loader and spinner
	////////////////////////////////////////////////////////////
	localparam logic [7:0] dip_index = 8'd254; // Loader index of the DIP bank
	localparam int         dip_bytes = 8;

	localparam int         pos_w     = 12;      // Signed spinner position
	localparam logic [1:0] quad_rest = 2'b11;   // Encoder code out of reset

	// D-pad position loads, one per poll period
	localparam logic [pos_w-1:0] dpad_slow = 12'd4;
	localparam logic [pos_w-1:0] dpad_fast = 12'd9;

	// Next AB code, dir 1 runs 00 01 11 10
	function automatic logic [1:0] quad_step(input logic dir, input logic [1:0] code);
		logic [1:0] nxt;
		case ({dir, code})
			3'b1_00: nxt = 2'b01;
			3'b1_01: nxt = 2'b11;
			3'b1_11: nxt = 2'b10;
			3'b1_10: nxt = 2'b00;
			3'b0_00: nxt = 2'b10; // Reverse order
			3'b0_10: nxt = 2'b11;
			3'b0_11: nxt = 2'b01;
			default: nxt = 2'b00; // 0_01
		endcase
		return nxt;
	endfunction

endpackage

//--- dip_switch_bank.sv
// DIP switch bank written by the loader
// Eight active-low bytes, byte 0 offered to the game

`timescale 1ns/1ns

module dip_switch_bank import arkanoid_controls_pkg::*; (
	input  logic        CLK_12M,
	input  logic        rst_n,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [7:0]  dip_sw
);

	logic [7:0] bank [dip_bytes]; // Active low, as the loader sends them
	logic       wr_en;

	// Only the first eight addresses of the DIP index
	assign wr_en = ioctl_wr && (ioctl_index == dip_index) && (ioctl_addr[24:3] == '0);

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			for (int i = 0; i < dip_bytes; i++)
				bank[i] <= 8'h00;
		end else if (wr_en) begin
			bank[ioctl_addr[2:0]] <= ioctl_dout;
		end
	end

	assign dip_sw = ~bank[0]; // Game wants active high

	// Out-of-range loader address never reaches the game
	a_dip_range: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		(ioctl_wr && (|ioctl_addr[24:3])) |=> $stable(dip_sw));

endmodule

//--- emulated_spinner.sv
// Emulated spinner for mouse and D-pad play
// Signed position accumulator and half-rate step divider
// Position drains one unit per step into an AB quadrature code

`timescale 1ns/1ns

module emulated_spinner import arkanoid_controls_pkg::*; #(
	parameter int step_div   = 1500,  // Enable periods per quadrature step
	parameter int poll_ticks = 48000  // Enable periods per D-pad load
) (
	input  logic        CLK_12M,
	input  logic        rst_n,
	input  logic [24:0] ps2_mouse,   // [24] toggle, [15:8] dx, [4] dx sign
	input  logic        left,
	input  logic        right,
	input  logic        fast,
	output logic [1:0]  emu_spinner,
	output logic        emu_active   // Emulated input seen this cycle
);

	localparam int div_w  = $clog2(step_div + 1);
	localparam int poll_w = $clog2(poll_ticks + 1);

	logic                ce;          // Half-rate enable
	logic [div_w-1:0]    div;
	logic [poll_w-1:0]   poll_cnt;
	logic [pos_w-1:0]    position;    // Two's complement
	logic [1:0]          code;
	logic                old_mouse;

	logic                mouse_evt;
	logic                dpad;
	logic                step_now;
	logic                add_ok;
	logic                poll_hit;
	logic [pos_w-1:0]    dx;
	logic [pos_w-1:0]    pos_stepped;
	logic [pos_w-1:0]    pos_mouse;
	logic [pos_w-1:0]    dpad_load;

	assign mouse_evt = ps2_mouse[24] != old_mouse;
	assign dpad      = left | right;

	// 9-bit dx, sign in bit 4
	assign dx = {{(pos_w - 8){ps2_mouse[4]}}, ps2_mouse[15:8]};

	////////////////////////////////////////////////////////////
	// Next position
	////////////////////////////////////////////////////////////
	assign step_now = (div == '0) && (position != '0);

	always_comb begin
		pos_stepped = position;
		if (step_now) begin
			if (position[pos_w-1])
				pos_stepped = position + pos_w'(1); // Negative, climb to zero
			else
				pos_stepped = position - pos_w'(1);
		end
	end

	// Top two bits equal means the add cannot wrap
	assign add_ok    = position[pos_w-1] == position[pos_w-2];
	assign pos_mouse = (mouse_evt && add_ok) ? pos_stepped + dx : pos_stepped;

	assign poll_hit  = dpad && (poll_cnt == poll_w'(poll_ticks));

	// Right wins over left
	always_comb begin
		if (right)
			dpad_load = fast ? dpad_fast : dpad_slow;
		else
			dpad_load = fast ? -dpad_fast : -dpad_slow;
	end

	////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			ce        <= 1'b0;
			div       <= '0;
			poll_cnt  <= '0;
			position  <= '0;
			code      <= quad_rest;
			old_mouse <= ps2_mouse[24]; // No event on reset release
		end else begin
			ce <= ~ce;
			if (ce) begin
				old_mouse <= ps2_mouse[24];

				if (div == div_w'(step_div - 1))
					div <= '0;
				else
					div <= div + div_w'(1);

				if (step_now)
					code <= quad_step(position[pos_w-1], code); // Toward the sign

				// D-pad load overrides mouse and drain
				position <= poll_hit ? dpad_load : pos_mouse;

				if (!dpad || poll_hit)
					poll_cnt <= '0;
				else
					poll_cnt <= poll_cnt + poll_w'(1);
			end
		end
	end

	assign emu_spinner = code;
	assign emu_active  = ce & (mouse_evt | dpad);

	// Quadrature output never skips a code
	a_emu_gray: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		$countones(emu_spinner ^ $past(emu_spinner)) <= 1);

endmodule

//--- encoder_input.sv
// Real quadrature encoder follower on two user pins
// Half edge rate, one code step per A edge
// Source select between real encoder and emulated spinner

`timescale 1ns/1ns

module encoder_input import arkanoid_controls_pkg::*; (
	input  logic       CLK_12M,
	input  logic       rst_n,
	input  logic       enc_a,
	input  logic       enc_b,
	input  logic [1:0] emu_spinner,
	input  logic       emu_active,   // Emulated input, hands control back
	output logic [1:0] spinner
);

	logic [1:0] raw_code;
	logic       old_a;
	logic       old_b;
	logic       use_io;  // Real encoder owns the output
	logic       a_edge;
	logic       pin_evt;

	assign a_edge  = enc_a != old_a;
	assign pin_evt = a_edge | (enc_b != old_b);

	always_ff @(posedge CLK_12M) begin
		old_a <= enc_a; // Sampled in reset too
		old_b <= enc_b;
		if (!rst_n) begin
			raw_code <= quad_rest;
			use_io   <= 1'b0;       // Start on emulated
		end else begin
			// A XOR B after the edge gives direction
			if (a_edge)
				raw_code <= quad_step(enc_a ^ enc_b, raw_code);

			if (pin_evt)
				use_io <= 1'b1;     // Pin activity wins
			else if (emu_active)
				use_io <= 1'b0;
		end
	end

	assign spinner = use_io ? raw_code : emu_spinner;

	// Raw code moves one bit at a time
	a_raw_gray: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		$countones(raw_code ^ $past(raw_code)) <= 1);

endmodule

//--- player_buttons.sv
// PS/2 key decoder for the cabinet buttons
// Merge of keyboard, joystick, mouse buttons and fire pin
// Game side start, shot and service are active low

`timescale 1ns/1ns

module player_buttons import arkanoid_controls_pkg::*; (
	input  logic        CLK_12M,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,       // [10] toggle, [9] pressed, [7:0] code
	input  logic [1:0]  ps2_mouse_btn,
	input  logic [8:0]  joy,
	input  logic        fire_n,        // Hardware fire pin, low when pressed
	output logic        left,
	output logic        right,
	output logic        fast,
	output logic        btn_shot,
	output logic        btn_service,
	output logic        btn_1p_start,
	output logic        btn_2p_start,
	output logic        coin1,
	output logic        coin2
);

	logic old_toggle;
	logic key_evt;
	logic pressed;

	// One held state per scan code
	logic k_start1, k_start2;
	logic k_coin1, k_coin2;
	logic k_service;
	logic k_fast, k_left, k_right, k_fire;

	assign key_evt = ps2_key[10] != old_toggle; // Every level change is one event
	assign pressed = ps2_key[9];

	////////////////////////////////////////////////////////////
	// Key registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_12M) begin
		old_toggle <= ps2_key[10]; // Tracks in reset too, no stray event
		if (!rst_n) begin
			k_start1  <= 1'b0;
			k_start2  <= 1'b0;
			k_coin1   <= 1'b0;
			k_coin2   <= 1'b0;
			k_service <= 1'b0;
			k_fast    <= 1'b0;
			k_left    <= 1'b0;
			k_right   <= 1'b0;
			k_fire    <= 1'b0;
		end else if (key_evt) begin
			case (ps2_key[7:0])
				key_start1:  k_start1  <= pressed;
				key_start2:  k_start2  <= pressed;
				key_coin1:   k_coin1   <= pressed;
				key_coin2:   k_coin2   <= pressed;
				key_service: k_service <= pressed;
				key_fast:    k_fast    <= pressed;
				key_left:    k_left    <= pressed;
				key_right:   k_right   <= pressed;
				key_fire:    k_fire    <= pressed;
				default: ; // Other keys ignored
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Button merge
	////////////////////////////////////////////////////////////
	assign left  = k_left  | joy[1];
	assign right = k_right | joy[0];
	assign fast  = k_fast  | joy[5];
	assign coin1 = k_coin1 | joy[7];
	assign coin2 = k_coin2;           // Keyboard only

	// Active low towards the game
	assign btn_shot     = ~(k_fire | joy[4] | (|ps2_mouse_btn) | ~fire_n);
	assign btn_service  = ~k_service;
	assign btn_1p_start = ~(k_start1 | joy[6]);
	assign btn_2p_start = ~(k_start2 | joy[8]);

endmodule

//--- tb_model.svh
// Testbench reference model
// Xorshift generator, quadrature position counters, step check

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit xorshift, never returns zero for a nonzero seed
function automatic logic [31:0] next_rand(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Position of an AB code in the forward order 00 01 11 10
function automatic int code_to_pos(input logic [1:0] code);
	case (code)
		2'b00: return 0;
		2'b01: return 1;
		2'b11: return 2;
		default: return 3;
	endcase
endfunction

function automatic logic [1:0] pos_to_code(input int pos);
	int p;
	p = ((pos % 4) + 4) % 4; // Wraps negative counts too
	case (p)
		0: return 2'b00;
		1: return 2'b01;
		2: return 2'b11;
		default: return 2'b10;
	endcase
endfunction

// +1 forward, -1 reverse, 0 still, 2 for a skipped code
function automatic int step_delta(input logic [1:0] prev, input logic [1:0] cur);
	int d;
	d = (code_to_pos(cur) - code_to_pos(prev) + 4) % 4;
	if (d == 3)
		return -1;
	return d;
endfunction

`endif

//--- tb_arkanoid_controls.sv
// Testbench for the paddle input front end
// Random keys, button merge, DIP writes, emulated spin, real encoder
// Reference model in tb_model.svh, watchdog and summary line

`timescale 1ns/1ns

module tb_arkanoid_controls import arkanoid_controls_pkg::*;;

	localparam int step_div   = 4;
	localparam int poll_ticks = 20;
	localparam int n_keys     = 200;
	localparam int n_merge    = 200;
	localparam int n_dip      = 200;
	localparam int n_spin     = 8;
	localparam int n_enc      = 60;
	localparam int spin_max   = 256 * 2 * step_div + 200; // Longest single spin
	localparam int total_cyc  = 20 + 2 * (n_keys + n_merge + n_dip) + 40
		+ 200 + (n_spin + 4) * spin_max + 3 * n_enc;
	localparam longint timeout_ns = 2 * longint'(total_cyc) * 40;

	logic        CLK_12M;
	logic        rst_n;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic [8:0]  joy;
	logic [3:0]  user_in;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [1:0]  spinner;
	logic        btn_shot, btn_service, btn_1p_start, btn_2p_start;
	logic        coin1, coin2;
	logic [7:0]  dip_sw;

	logic [31:0] rng = 32'd17872;
	int          errors = 0;
	int          tests = 0;
	int          tests_failed = 0;
	int          test_start;
	logic [7:0]  codes [9] = '{key_start1, key_start2, key_coin1, key_coin2, key_service,
		key_fast, key_left, key_right, key_fire};
	logic        key_state [9];  // Model key registers, same order as codes
	logic [7:0]  dip_model [8];
	logic [1:0]  emu_code;       // Model emulated code
	int          raw_pos;        // Model raw encoder position

	`include "tb_model.svh"

	arkanoid_controls #(.step_div(step_div), .poll_ticks(poll_ticks)) UUT (
		.CLK_12M(CLK_12M), .rst_n(rst_n), .ps2_key(ps2_key), .ps2_mouse(ps2_mouse),
		.joy(joy), .user_in(user_in), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .spinner(spinner),
		.btn_shot(btn_shot), .btn_service(btn_service), .btn_1p_start(btn_1p_start),
		.btn_2p_start(btn_2p_start), .coin1(coin1), .coin2(coin2), .dip_sw(dip_sw)
	);

	initial begin
		CLK_12M = 1'b0;
		forever #20 CLK_12M = ~CLK_12M; // 40 ns period
	end

	initial begin
		#(timeout_ns);
		$display("Watchdog expired, the run did not finish in time");
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] draw_random();
		rng = next_rand(rng);
		return rng;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("error %s: expected %0h, actual %0h", name, exp, act);
	endtask

	task automatic begin_test();
		test_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_start)
			tests_failed++;
		$display("%s: %s", name, (errors == test_start) ? "ok" : "failed");
	endtask

	////////////////////////////////////////////////////////////
	// Buttons
	////////////////////////////////////////////////////////////
	task automatic check_buttons(input string name);
		logic       fire;
		logic [5:0] exp;
		fire = key_state[8] | joy[4] | (|ps2_mouse[1:0]) | ~user_in[3];
		exp = {~fire, ~key_state[4], ~(key_state[0] | joy[6]), ~(key_state[1] | joy[8]),
			key_state[2] | joy[7], key_state[3]};
		if ({btn_shot, btn_service, btn_1p_start, btn_2p_start, coin1, coin2} != exp)
			mismatch(name, exp, {btn_shot, btn_service, btn_1p_start, btn_2p_start, coin1, coin2});
	endtask

	// Caller sits on a falling edge
	task automatic send_key(input logic [7:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		for (int i = 0; i < 9; i++)
			if (codes[i] == code)
				key_state[i] = pressed;
	endtask

	task automatic release_keys();
		for (int i = 0; i < 9; i++) begin
			@(negedge CLK_12M);
			send_key(codes[i], 1'b0);
		end
		@(negedge CLK_12M);
	endtask

	function automatic logic [7:0] pick_code();
		logic [31:0] r;
		logic [7:0]  unused [3] = '{8'h1C, 8'h5A, 8'h76};
		r = draw_random();
		if (r[3:0] < 4'd9)
			return codes[r[3:0]];
		return unused[r[5:4] % 3];
	endfunction

	////////////////////////////////////////////////////////////
	// Spinner
	////////////////////////////////////////////////////////////
	task automatic send_mouse(input logic [8:0] dxv);
		@(negedge CLK_12M);
		ps2_mouse = {~ps2_mouse[24], 8'h00, dxv[7:0], 3'b000, dxv[8], 4'b0000};
	endtask

	// Follows spinner until it rests, counts net forward steps
	task automatic run_spin(input string name, input int exp_net, input int min_cyc);
		logic [1:0] prev;
		int         net;
		int         still;
		int         guard;
		int         d;
		guard = 0;
		while (spinner != emu_code && guard < 64) begin
			@(negedge CLK_12M);
			guard++;
		end
		if (spinner != emu_code)
			mismatch({name, " return"}, emu_code, spinner);
		prev = emu_code;
		net = 0;
		still = 0;
		guard = 0;
		while ((still <= 4 * step_div || guard < min_cyc) && guard < spin_max + min_cyc) begin
			@(negedge CLK_12M);
			guard++;
			d = step_delta(prev, spinner);
			if (d == 2) begin
				errors++;
				$display("%s: spinner skipped a code, %b to %b", name, prev, spinner);
			end
			if (spinner != prev) begin
				net += d;
				still = 0;
				prev = spinner;
			end else begin
				still++;
			end
		end
		if (still <= 4 * step_div) begin
			errors++;
			$display("%s: spinner never came to rest", name);
		end
		if (net != exp_net)
			mismatch({name, " net"}, exp_net, net);
		emu_code = prev;
	endtask

	task automatic hold_joy(input logic [8:0] value, input int cycles);
		@(negedge CLK_12M);
		joy = value;
		repeat (cycles) @(negedge CLK_12M);
		joy = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] r;
		logic [8:0]  dxv;
		logic [1:0]  pins;
		logic        old_a;
		int          gpos;
		logic [1:0]  gray [4] = '{2'b00, 2'b01, 2'b11, 2'b10}; // {b, a}
		rst_n = 1'b0;
		ps2_key = '0;
		ps2_mouse = '0;
		joy = '0;
		user_in = 4'b1000; // Fire pin idle high
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		for (int i = 0; i < 9; i++)
			key_state[i] = 1'b0;
		for (int i = 0; i < 8; i++)
			dip_model[i] = 8'h00;
		repeat (3) @(posedge CLK_12M); // Three reset edges
		@(negedge CLK_12M);
		rst_n = 1'b1;
		@(negedge CLK_12M);

		begin_test(); // Reset values
		if (spinner != quad_rest)
			mismatch("reset spinner", quad_rest, spinner);
		check_buttons("reset buttons");
		if (dip_sw != 8'hFF)
			mismatch("reset dip_sw", 8'hFF, dip_sw);
		end_test("reset");

		begin_test();
		for (int n = 0; n < n_keys; n++) begin
			r = draw_random();
			send_key(pick_code(), r[8]);
			@(negedge CLK_12M);
			check_buttons("keyboard");
		end
		release_keys();
		end_test("keyboard");

		begin_test();
		for (int n = 0; n < n_merge; n++) begin
			r = draw_random();
			if (r[0])
				send_key(pick_code(), r[1]);
			joy = r[12:4];
			ps2_mouse[1:0] = r[14:13];
			user_in[3] = r[15];
			@(negedge CLK_12M);
			check_buttons("merge");
		end
		joy = '0;
		ps2_mouse[1:0] = 2'b00;
		user_in[3] = 1'b1;
		release_keys();
		end_test("button merge");

		begin_test();
		for (int n = 0; n < n_dip; n++) begin
			r = draw_random();
			ioctl_wr = r[0] | r[1];
			ioctl_index = r[2] ? dip_index : r[10:3];
			ioctl_addr = r[11] ? {22'b0, r[14:12]} : {r[31:15], r[14:12], 5'b0};
			r = draw_random();
			ioctl_dout = r[7:0];
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr[24:3] == 22'b0)
				dip_model[ioctl_addr[2:0]] = ioctl_dout;
			@(negedge CLK_12M);
			ioctl_wr = 1'b0;
			if (dip_sw != ~dip_model[0])
				mismatch("dip_sw", ~dip_model[0], dip_sw);
		end
		end_test("dip bank");

		begin_test();
		repeat (200) @(negedge CLK_12M); // D-pad loads from earlier tests drain
		emu_code = spinner;
		for (int n = 0; n < n_spin; n++) begin
			r = draw_random();
			dxv = r[8:0];
			send_mouse(dxv);
			// Positive position steps the reverse order
			run_spin("mouse", -int'($signed(dxv)), 0);
		end
		fork
			hold_joy(9'b000100001, 60); // Right with fast, one load
			run_spin("dpad right fast", -9, 80);
		join
		fork
			hold_joy(9'b000000001, 60);
			run_spin("dpad right", -4, 80);
		join
		fork
			hold_joy(9'b000000010, 60);
			run_spin("dpad left", 4, 80);
		join
		end_test("mouse and dpad spin");

		begin_test();
		raw_pos = code_to_pos(quad_rest);
		gpos = 0;
		pins = 2'b00;
		for (int n = 0; n < n_enc; n++) begin
			r = draw_random();
			gpos = r[0] ? gpos + 1 : gpos + 3;
			old_a = pins[0];
			pins = gray[gpos % 4];
			@(negedge CLK_12M);
			user_in[1:0] = pins;
			if (pins[0] != old_a)
				raw_pos = (pins[0] ^ pins[1]) ? raw_pos + 1 : raw_pos - 1;
			@(negedge CLK_12M);
			if (spinner != pos_to_code(raw_pos))
				mismatch("encoder", pos_to_code(raw_pos), spinner);
		end
		r = draw_random();
		dxv = r[8:0];
		if (dxv == 9'd0)
			dxv = 9'd5;
		send_mouse(dxv);
		run_spin("encoder handback", -int'($signed(dxv)), 0);
		end_test("real encoder");

		$display("Tests run %0d, tests failed %0d, check errors %0d", tests, tests_failed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
